// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
TOP       := tb_mmio_subsys
FILELIST  := all.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run from the project root so the vector file path resolves
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
source/mmio_pkg.sv
source/tl_arbiter.sv
source/mmio_router.sv
source/virtio_blk_regs.sv
source/uart_tx_regs.sv
source/mmio_subsys.sv
testbench/tb_mmio_subsys.sv

// File: source/mmio_pkg.sv
package mmio_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  source_t;     // {port, requester tag}.
    typedef logic [7:0]  uart_byte_t;
    typedef logic [31:0] queue_sel_t;
    typedef logic [7:0]  dev_status_t;

    // a and d channel codes share one enum, so they stay distinct.
    typedef enum logic [2:0] {
        TL_PUT_FULL        = 3'd0,
        TL_ACCESS_ACK_DATA = 3'd1,
        TL_ACCESS_ACK      = 3'd2,
        TL_GET             = 3'd4
    } tl_op_e;

    typedef struct packed {
        tl_op_e  opcode;
        size_t   size;
        source_t source;
        addr_t   address;
        data_t   data;
    } tl_a_t;

    typedef struct packed {
        tl_op_e  opcode;
        size_t   size;
        source_t source;
        logic    denied;
        data_t   data;
    } tl_d_t;

    localparam int NUM_PORTS       = 2;
    localparam int PORT_CREDITS    = 2;     // queue depth per port.
    localparam int UART_FIFO_DEPTH = 4;

    typedef logic [$clog2(NUM_PORTS)-1:0]         port_t;
    typedef logic [$clog2(PORT_CREDITS)-1:0]      qptr_t;
    typedef logic [$clog2(PORT_CREDITS+1)-1:0]    qcnt_t;
    typedef logic [$clog2(UART_FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(UART_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    localparam addr_t UART_BASE   = 32'h1000_0000;
    localparam addr_t VIRTIO_BASE = 32'h1000_1000;
    localparam addr_t WINDOW_SIZE = 32'h0000_1000;

    localparam addr_t VIRTIO_MAGIC           = 32'h000;
    localparam addr_t VIRTIO_VERSION         = 32'h004;
    localparam addr_t VIRTIO_DEVICE_ID       = 32'h008;
    localparam addr_t VIRTIO_VENDOR_ID       = 32'h00c;
    localparam addr_t VIRTIO_DEVICE_FEATURES = 32'h010;
    localparam addr_t VIRTIO_QUEUE_SEL       = 32'h030;
    localparam addr_t VIRTIO_STATUS          = 32'h070;

    localparam data_t VIRTIO_MAGIC_VALUE    = 64'h7472_6976;  // "virt".
    localparam data_t VIRTIO_VERSION_VALUE  = 64'h1;
    localparam data_t VIRTIO_ID_BLOCK       = 64'h2;
    localparam data_t VIRTIO_VENDOR_VALUE   = 64'h554d_4551;  // "QEMU".
    localparam data_t VIRTIO_FEATURES_VALUE = 64'h3100_6ed4;

    localparam addr_t UART_TX    = 32'h000;
    localparam addr_t UART_LEVEL = 32'h008;

    function automatic tl_op_e ack_op(input tl_op_e op);
        return (op == TL_GET) ? TL_ACCESS_ACK_DATA : TL_ACCESS_ACK;
    endfunction

endpackage

// File: source/mmio_router.sv
`timescale 1ns/10ps

module mmio_router (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            bus_valid,
    input  mmio_pkg::tl_a_t bus_req,
    output logic            bus_rsp_valid,
    output mmio_pkg::tl_d_t bus_rsp,
    output logic            blk_valid,
    output mmio_pkg::tl_a_t blk_req,
    input  logic            blk_rsp_valid,
    input  mmio_pkg::tl_d_t blk_rsp,
    output logic            uart_valid,
    output mmio_pkg::tl_a_t uart_req,
    input  logic            uart_rsp_valid,
    input  mmio_pkg::tl_d_t uart_rsp
);

    mmio_pkg::addr_t win_base;
    mmio_pkg::tl_a_t fwd_req;
    logic            in_blk;
    logic            in_uart;
    logic            deny_valid;
    mmio_pkg::tl_d_t deny_rsp;

    assign win_base = bus_req.address & ~(mmio_pkg::WINDOW_SIZE - 1);
    assign in_blk   = (win_base == mmio_pkg::VIRTIO_BASE);
    assign in_uart  = (win_base == mmio_pkg::UART_BASE);

    always_comb begin
        fwd_req = bus_req;
        fwd_req.address = bus_req.address & (mmio_pkg::WINDOW_SIZE - 1);  // offset only.
    end

    assign blk_valid  = bus_valid && in_blk;
    assign blk_req    = fwd_req;
    assign uart_valid = bus_valid && in_uart;
    assign uart_req   = fwd_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deny_valid <= 1'b0;
        end else begin
            deny_valid <= bus_valid && !in_blk && !in_uart;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_valid) begin
            deny_rsp.opcode <= mmio_pkg::ack_op(bus_req.opcode);
            deny_rsp.size   <= bus_req.size;
            deny_rsp.source <= bus_req.source;
            deny_rsp.denied <= 1'b1;
            deny_rsp.data   <= '0;
        end
    end

    always_comb begin
        bus_rsp_valid = blk_rsp_valid | uart_rsp_valid | deny_valid;
        if (blk_rsp_valid) begin
            bus_rsp = blk_rsp;
        end else if (uart_rsp_valid) begin
            bus_rsp = uart_rsp;
        end else begin
            bus_rsp = deny_rsp;
        end
    end

    a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({blk_rsp_valid, uart_rsp_valid, deny_valid}));

endmodule

// File: source/mmio_subsys.sv
`timescale 1ns/10ps

module mmio_subsys (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mmio_pkg::NUM_PORTS-1:0] req_valid,
    input  mmio_pkg::tl_a_t                req [mmio_pkg::NUM_PORTS],
    output logic [mmio_pkg::NUM_PORTS-1:0] credit,
    output logic [mmio_pkg::NUM_PORTS-1:0] rsp_valid,
    output mmio_pkg::tl_d_t                rsp [mmio_pkg::NUM_PORTS],
    output logic                           tx_valid,
    output mmio_pkg::uart_byte_t           tx_byte,
    input  logic                           tx_ready
);

    logic            bus_valid;
    mmio_pkg::tl_a_t bus_req;
    logic            bus_rsp_valid;
    mmio_pkg::tl_d_t bus_rsp;
    logic            blk_valid;
    mmio_pkg::tl_a_t blk_req;
    logic            blk_rsp_valid;
    mmio_pkg::tl_d_t blk_rsp;
    logic            uart_valid;
    mmio_pkg::tl_a_t uart_req;
    logic            uart_rsp_valid;
    mmio_pkg::tl_d_t uart_rsp;

    tl_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .credit        (credit),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .bus_valid     (bus_valid),
        .bus_req       (bus_req),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp       (bus_rsp)
    );

    mmio_router u_router (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus_valid      (bus_valid),
        .bus_req        (bus_req),
        .bus_rsp_valid  (bus_rsp_valid),
        .bus_rsp        (bus_rsp),
        .blk_valid      (blk_valid),
        .blk_req        (blk_req),
        .blk_rsp_valid  (blk_rsp_valid),
        .blk_rsp        (blk_rsp),
        .uart_valid     (uart_valid),
        .uart_req       (uart_req),
        .uart_rsp_valid (uart_rsp_valid),
        .uart_rsp       (uart_rsp)
    );

    virtio_blk_regs u_blk (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_valid (blk_valid),
        .sel_req   (blk_req),
        .rsp_valid (blk_rsp_valid),
        .rsp       (blk_rsp)
    );

    uart_tx_regs u_uart (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_valid (uart_valid),
        .sel_req   (uart_req),
        .rsp_valid (uart_rsp_valid),
        .rsp       (uart_rsp),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .tx_ready  (tx_ready)
    );

endmodule

// File: source/tl_arbiter.sv
`timescale 1ns/10ps

module tl_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mmio_pkg::NUM_PORTS-1:0] req_valid,
    input  mmio_pkg::tl_a_t                req [mmio_pkg::NUM_PORTS],
    output logic [mmio_pkg::NUM_PORTS-1:0] credit,
    output logic [mmio_pkg::NUM_PORTS-1:0] rsp_valid,
    output mmio_pkg::tl_d_t                rsp [mmio_pkg::NUM_PORTS],
    output logic                           bus_valid,
    output mmio_pkg::tl_a_t                bus_req,
    input  logic                           bus_rsp_valid,
    input  mmio_pkg::tl_d_t                bus_rsp
);

    mmio_pkg::tl_a_t                head [mmio_pkg::NUM_PORTS];
    logic [mmio_pkg::NUM_PORTS-1:0] nonempty;
    logic [mmio_pkg::NUM_PORTS-1:0] pop;
    logic                           tag_hi [mmio_pkg::NUM_PORTS];
    mmio_pkg::qcnt_t                pend_cnt [mmio_pkg::NUM_PORTS];
    mmio_pkg::port_t                rr_ptr;
    mmio_pkg::port_t                grant;

    // first non-empty port at or after the pointer.
    always_comb begin
        int idx;
        grant = rr_ptr;
        for (int i = mmio_pkg::NUM_PORTS - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % mmio_pkg::NUM_PORTS;
            if (nonempty[idx]) begin
                grant = mmio_pkg::port_t'(idx);
            end
        end
    end

    assign bus_valid = |nonempty;

    always_comb begin
        bus_req = head[grant];
        bus_req.source = {grant, head[grant].source[0]};  // port into upper bit.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (bus_valid) begin
            rr_ptr <= mmio_pkg::port_t'((int'(grant) + 1) % mmio_pkg::NUM_PORTS);
        end
    end

    for (genvar p = 0; p < mmio_pkg::NUM_PORTS; p++) begin : g_port
        mmio_pkg::tl_a_t mem [mmio_pkg::PORT_CREDITS];
        mmio_pkg::qptr_t wr_ptr;
        mmio_pkg::qptr_t rd_ptr;
        mmio_pkg::qcnt_t count;

        assign nonempty[p] = (count != '0);
        assign head[p]     = mem[rd_ptr];
        assign pop[p]      = bus_valid && (grant == mmio_pkg::port_t'(p));
        assign credit[p]   = pop[p];  // slot frees on issue.

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr      <= '0;
                rd_ptr      <= '0;
                count       <= '0;
                pend_cnt[p] <= '0;
            end else begin
                if (req_valid[p]) begin
                    wr_ptr <= (wr_ptr == mmio_pkg::qptr_t'(mmio_pkg::PORT_CREDITS - 1)) ?
                              '0 : wr_ptr + 1'b1;
                end
                if (pop[p]) begin
                    rd_ptr <= (rd_ptr == mmio_pkg::qptr_t'(mmio_pkg::PORT_CREDITS - 1)) ?
                              '0 : rd_ptr + 1'b1;
                end
                case ({req_valid[p], pop[p]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: ;
                endcase
                case ({pop[p], rsp_valid[p]})
                    2'b10:   pend_cnt[p] <= pend_cnt[p] + 1'b1;
                    2'b01:   pend_cnt[p] <= pend_cnt[p] - 1'b1;
                    default: ;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (req_valid[p]) begin
                mem[wr_ptr] <= req[p];
            end
            if (pop[p]) begin
                tag_hi[p] <= head[p].source[1];  // requester's own upper bit.
            end
        end

        assign rsp_valid[p] = bus_rsp_valid && (bus_rsp.source[1] == mmio_pkg::port_t'(p));

        always_comb begin
            rsp[p] = bus_rsp;
            rsp[p].source[1] = tag_hi[p];
        end

        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            req_valid[p] |-> (count != mmio_pkg::qcnt_t'(mmio_pkg::PORT_CREDITS)) || pop[p]);
    end

    a_rsp_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp_valid |-> $past(bus_valid));

    a_rsp_port_pending: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp_valid |-> (pend_cnt[bus_rsp.source[1]] != '0));

endmodule

// File: source/uart_tx_regs.sv
`timescale 1ns/10ps

module uart_tx_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sel_valid,
    input  mmio_pkg::tl_a_t      sel_req,
    output logic                 rsp_valid,
    output mmio_pkg::tl_d_t      rsp,
    output logic                 tx_valid,
    output mmio_pkg::uart_byte_t tx_byte,
    input  logic                 tx_ready
);

    mmio_pkg::uart_byte_t fifo [mmio_pkg::UART_FIFO_DEPTH];
    mmio_pkg::fifo_ptr_t  wr_ptr;
    mmio_pkg::fifo_ptr_t  rd_ptr;
    mmio_pkg::fifo_cnt_t  level;
    logic                 is_get;
    logic                 is_tx;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign is_get = (sel_req.opcode == mmio_pkg::TL_GET);
    assign is_tx  = (sel_req.address == mmio_pkg::UART_TX);
    assign full   = (level == mmio_pkg::fifo_cnt_t'(mmio_pkg::UART_FIFO_DEPTH));
    assign push   = sel_valid && !is_get && is_tx && !full;
    assign pop    = tx_valid && tx_ready;

    assign tx_valid = (level != '0);
    assign tx_byte  = fifo[rd_ptr];

    // pointers wrap naturally as the depth is a power of two.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= sel_valid;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= sel_req.data[7:0];
        end
        if (sel_valid) begin
            rsp.opcode <= mmio_pkg::ack_op(sel_req.opcode);
            rsp.size   <= sel_req.size;
            rsp.source <= sel_req.source;
            rsp.denied <= !is_get && is_tx && full;  // byte dropped.
            rsp.data   <= (is_get && sel_req.address == mmio_pkg::UART_LEVEL) ?
                          mmio_pkg::data_t'(level) : '0;
        end
    end

    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte));

endmodule

// File: source/virtio_blk_regs.sv
`timescale 1ns/10ps

module virtio_blk_regs (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sel_valid,
    input  mmio_pkg::tl_a_t sel_req,
    output logic            rsp_valid,
    output mmio_pkg::tl_d_t rsp
);

    mmio_pkg::queue_sel_t  queue_sel;
    mmio_pkg::dev_status_t status;
    mmio_pkg::data_t       rd_data;
    logic                  is_get;
    logic                  wr_en;

    assign is_get = (sel_req.opcode == mmio_pkg::TL_GET);
    assign wr_en  = sel_valid && (sel_req.opcode == mmio_pkg::TL_PUT_FULL);

    always_comb begin
        case (sel_req.address)
            mmio_pkg::VIRTIO_MAGIC: begin
                rd_data = mmio_pkg::VIRTIO_MAGIC_VALUE;
            end
            mmio_pkg::VIRTIO_VERSION: begin
                rd_data = mmio_pkg::VIRTIO_VERSION_VALUE;
            end
            mmio_pkg::VIRTIO_DEVICE_ID: begin
                rd_data = mmio_pkg::VIRTIO_ID_BLOCK;
            end
            mmio_pkg::VIRTIO_VENDOR_ID: begin
                rd_data = mmio_pkg::VIRTIO_VENDOR_VALUE;
            end
            mmio_pkg::VIRTIO_DEVICE_FEATURES: begin
                rd_data = mmio_pkg::VIRTIO_FEATURES_VALUE;
            end
            mmio_pkg::VIRTIO_QUEUE_SEL: begin
                rd_data = mmio_pkg::data_t'(queue_sel);
            end
            mmio_pkg::VIRTIO_STATUS: begin
                rd_data = mmio_pkg::data_t'(status);
            end
            default: begin
                rd_data = '0;  // unimplemented offsets.
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            queue_sel <= '0;
            status    <= '0;
        end else begin
            rsp_valid <= sel_valid;
            if (wr_en) begin
                case (sel_req.address)
                    mmio_pkg::VIRTIO_QUEUE_SEL: begin
                        queue_sel <= sel_req.data[31:0];
                    end
                    mmio_pkg::VIRTIO_STATUS: begin
                        status <= sel_req.data[7:0];
                        // zero status is a device reset.
                        if (sel_req.data[7:0] == '0) begin
                            queue_sel <= '0;
                        end
                    end
                    default: ;  // dropped.
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            rsp.opcode <= mmio_pkg::ack_op(sel_req.opcode);
            rsp.size   <= sel_req.size;
            rsp.source <= sel_req.source;
            rsp.denied <= 1'b0;
            rsp.data   <= is_get ? rd_data : '0;
        end
    end

endmodule

// File: testbench/mmio_tests.txt
# Q port op(0 get,1 put) addr data exp_op(0 ack,1 ack_data) exp_denied exp_data
# R tx_ready, B expected uart byte, W wait until idle, M/E mixed section start/end
Q 0 0 10001000 0 1 0 74726976
Q 0 0 10001004 0 1 0 1
Q 0 0 10001008 0 1 0 2
Q 0 0 1000100c 0 1 0 554d4551
Q 0 0 10001010 0 1 0 31006ed4
Q 0 1 10001070 1a3 0 0 0
Q 0 1 10001030 deadbeef00000007 0 0 0
Q 0 0 10001070 0 1 0 a3
Q 0 0 10001030 0 1 0 7
W
Q 1 0 10001070 0 1 0 a3
Q 1 1 10001070 0 0 0 0
Q 1 0 10001070 0 1 0 0
Q 1 0 10001030 0 1 0 0
Q 1 1 10001044 1234 0 0 0
Q 1 0 10001044 0 1 0 0
Q 0 0 20000000 0 1 1 0
Q 1 1 10002000 55 0 1 0
W
R 0
Q 0 1 10000000 41 0 0 0
Q 0 1 10000000 42 0 0 0
Q 0 1 10000000 43 0 0 0
Q 0 1 10000000 44 0 0 0
Q 0 1 10000000 45 0 1 0
Q 0 0 10000008 0 1 0 4
W
B 41
B 42
B 43
B 44
R 1
W
Q 1 0 10000008 0 1 0 0
W
M
Q 0 0 10001000 0 1 0 74726976
Q 0 0 10001004 0 1 0 1
Q 0 0 10001008 0 1 0 2
Q 0 1 10001100 ff 0 0 0
Q 0 0 10001100 0 1 0 0
Q 0 0 1000100c 0 1 0 554d4551
Q 1 0 10001010 0 1 0 31006ed4
Q 1 0 1000100c 0 1 0 554d4551
Q 1 1 10001030 9 0 0 0
Q 1 0 10001030 0 1 0 9
Q 1 0 30000000 0 1 1 0
Q 1 0 10000000 0 1 0 0
Q 1 0 10001000 0 1 0 74726976
E
W

// File: testbench/tb_mmio_subsys.sv
`timescale 1ns/10ps

module tb_mmio_subsys;

    typedef struct packed {
        mmio_pkg::tl_a_t req;
        mmio_pkg::tl_d_t rsp;  // expected reply.
    } vec_t;

    localparam string VEC_FILE = "testbench/mmio_tests.txt";

    logic                           clk;
    logic                           rst_n;
    logic [mmio_pkg::NUM_PORTS-1:0] req_valid;
    mmio_pkg::tl_a_t                req [mmio_pkg::NUM_PORTS];
    logic [mmio_pkg::NUM_PORTS-1:0] credit;
    logic [mmio_pkg::NUM_PORTS-1:0] rsp_valid;
    mmio_pkg::tl_d_t                rsp [mmio_pkg::NUM_PORTS];
    logic                           tx_valid;
    mmio_pkg::uart_byte_t           tx_byte;
    logic                           tx_ready;

    logic [mmio_pkg::NUM_PORTS-1:0] nxt_valid;
    mmio_pkg::tl_a_t                nxt_req [mmio_pkg::NUM_PORTS];
    logic                           nxt_ready;
    int                             credits [mmio_pkg::NUM_PORTS];
    logic                           tag_bit [mmio_pkg::NUM_PORTS];
    vec_t                           pend_q [mmio_pkg::NUM_PORTS][$];
    mmio_pkg::tl_d_t                exp_q [mmio_pkg::NUM_PORTS][$];
    mmio_pkg::uart_byte_t           exp_bytes [$];
    int                             cycles;
    int                             cycle_limit;
    int                             seed;

    mmio_subsys u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .credit    (credit),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .tx_ready  (tx_ready)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("Test FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    task automatic observe();
        mmio_pkg::tl_d_t want;
        for (int p = 0; p < mmio_pkg::NUM_PORTS; p++) begin
            if (credit[p]) begin
                credits[p]++;
                if (credits[p] > mmio_pkg::PORT_CREDITS) begin
                    abort_run($sformatf("port %0d got back more credits than it owns", p));
                end
            end
            if (rsp_valid[p]) begin
                if (exp_q[p].size() == 0) begin
                    abort_run($sformatf("port %0d got a response with nothing outstanding", p));
                end
                want = exp_q[p].pop_front();
                check($sformatf("port %0d opcode", p), 64'(rsp[p].opcode), 64'(want.opcode));
                check($sformatf("port %0d size", p), 64'(rsp[p].size), 64'(want.size));
                check($sformatf("port %0d source", p), 64'(rsp[p].source), 64'(want.source));
                check($sformatf("port %0d denied", p), 64'(rsp[p].denied), 64'(want.denied));
                check($sformatf("port %0d data", p), rsp[p].data, want.data);
            end
        end
        if (tx_valid && tx_ready) begin  // byte moves on the coming rising edge.
            if (exp_bytes.size() == 0) begin
                abort_run($sformatf("UART sent byte %0h that no vector expects", tx_byte));
            end
            check("tx_byte", 64'(tx_byte), 64'(exp_bytes.pop_front()));
        end
    endtask

    // apply staged inputs on the falling edge, then look at the outputs.
    task automatic step();
        @(negedge clk);
        req_valid = nxt_valid;
        tx_ready  = nxt_ready;
        for (int p = 0; p < mmio_pkg::NUM_PORTS; p++) begin
            req[p] = nxt_req[p];
        end
        nxt_valid = '0;
        observe();
        cycles++;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
    endtask

    task automatic issue_pending(input int first_port);
        logic [mmio_pkg::NUM_PORTS-1:0] allow;
        vec_t                           v;
        allow = (first_port < 0) ? '1 : 2'b01 << first_port;
        while (pend_q[0].size() != 0 || pend_q[1].size() != 0) begin
            for (int p = 0; p < mmio_pkg::NUM_PORTS; p++) begin
                if (allow[p] && pend_q[p].size() != 0 && credits[p] > 0) begin
                    v = pend_q[p].pop_front();
                    nxt_valid[p] = 1'b1;
                    nxt_req[p]   = v.req;
                    credits[p]--;
                    exp_q[p].push_back(v.rsp);
                end
            end
            step();
            allow = '1;
        end
    endtask

    function automatic logic is_idle();
        logic idle;
        idle = (exp_bytes.size() == 0);
        for (int p = 0; p < mmio_pkg::NUM_PORTS; p++) begin
            idle = idle && exp_q[p].size() == 0 && pend_q[p].size() == 0;
            idle = idle && credits[p] == mmio_pkg::PORT_CREDITS;
        end
        return idle;
    endfunction

    task automatic drain();
        while (!is_idle()) begin
            step();
        end
    endtask

    task automatic count_vectors(output int n);
        int    fd;
        string line;
        n  = 0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open ", VEC_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) inside {"Q", "R", "B", "W", "M", "E"}) begin
                n++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vectors();
        int          fd;
        int          n;
        int          port;
        int          op;
        int          eop;
        int          eden;
        int          ready;
        int          first;
        logic [31:0] addr;
        logic [63:0] data;
        logic [63:0] edata;
        logic [7:0]  tx_exp;
        string       line;
        string       rest;
        bit          mixed;
        vec_t        v;
        mixed = 1'b0;
        fd    = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open ", VEC_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            rest = line.substr(1, line.len() - 1);
            case (line.getc(0))
                "Q": begin
                    n = $sscanf(rest, "%d %d %h %h %d %d %h",
                                port, op, addr, data, eop, eden, edata);
                    if (n != 7 || port < 0 || port >= mmio_pkg::NUM_PORTS) begin
                        abort_run({"bad request line: ", line});
                    end
                    v.req.opcode  = (op == 1) ? mmio_pkg::TL_PUT_FULL : mmio_pkg::TL_GET;
                    v.req.size    = tag_bit[port] ? 3'd3 : 3'd2;
                    v.req.source  = {~tag_bit[port], tag_bit[port]};  // upper bit comes back.
                    v.req.address = addr;
                    v.req.data    = data;
                    v.rsp.opcode  = (eop == 1) ? mmio_pkg::TL_ACCESS_ACK_DATA
                                               : mmio_pkg::TL_ACCESS_ACK;
                    v.rsp.size    = v.req.size;   // echoed.
                    v.rsp.source  = v.req.source;
                    v.rsp.denied  = (eden != 0);
                    v.rsp.data    = edata;
                    tag_bit[port] = ~tag_bit[port];
                    pend_q[port].push_back(v);
                    if (!mixed) begin
                        issue_pending(-1);
                    end
                end
                "R": begin
                    n = $sscanf(rest, "%d", ready);
                    nxt_ready = (ready != 0);
                end
                "B": begin
                    n = $sscanf(rest, "%h", tx_exp);
                    exp_bytes.push_back(tx_exp);
                end
                "W": drain();
                "M": mixed = 1'b1;
                "E": begin
                    mixed = 1'b0;
                    first = $random(seed) & 1;  // port that starts the burst.
                    issue_pending(first);
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = '0;
        tx_ready  = 1'b1;
        nxt_valid = '0;
        nxt_ready = 1'b1;
        cycles    = 0;
        seed      = 32'hfe7c;
        for (int p = 0; p < mmio_pkg::NUM_PORTS; p++) begin
            req[p]     = '0;
            nxt_req[p] = '0;
            credits[p] = mmio_pkg::PORT_CREDITS;
            tag_bit[p] = 1'b0;
        end
        count_vectors(cycle_limit);
        cycle_limit = 20 * cycle_limit + 100;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        run_vectors();
        drain();
        $display("Test OK");
        $finish;
    end

endmodule
